// File: all.f
+incdir+common
common/mcu_pkg.sv
verilog/mcu_cmd_fifo.sv
verilog/mcu_ms_timer.sv
mcu_regs/mcu_bus_fsm.sv
mcu_regs/mcu_reg_bank.sv
verilog/mcu_periph_top.sv
tests/tb_clock_gen.sv
tests/mcu_periph_checker.sv
tests/tb_mcu_periph.sv

// File: Bender.yml
package:
  name: mcu_periph

sources:
  - include_dirs:
      - common
    files:
      - common/mcu_pkg.sv
      - verilog/mcu_cmd_fifo.sv
      - verilog/mcu_ms_timer.sv
      - mcu_regs/mcu_bus_fsm.sv
      - mcu_regs/mcu_reg_bank.sv
      - verilog/mcu_periph_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_clock_gen.sv
      - tests/mcu_periph_checker.sv
      - tests/tb_mcu_periph.sv

// File: tests/mcu_periph_testdata.txt
# name op off wdata exp, all hex, exp - means no check
# wr rd rdge rdlt bus access, wrp/wrc write plus port check, dsin host status, irq level (off 0 ext, 1 timer)
mbox wr 00 a5a50000 0
mbox rd 00 0 a5a50000
mbox wr 04 5a5a0104 0
mbox wr 08 deadbe08 0
mbox rd 04 0 5a5a0104
mbox rd 08 0 deadbe08
mbox wr 0c 0123450c 0
mbox wr 10 fedcba10 0
mbox wr 14 13579b14 0
mbox rd 0c 0 0123450c
mbox rd 10 0 fedcba10
mbox rd 14 0 13579b14
mbox wr 18 2468ac18 0
mbox wr 1c 0f0f0f1c 0
mbox rd 1c 0 0f0f0f1c
mbox rd 18 0 2468ac18
dsprm wrp 80 00001234 0
dsprm wrp 84 40000100 0
dsprm wrp 88 00000200 0
dsprm wrp 8c 00000040 0
dsprm rd 80 0 00001234
dsprm rd 84 0 40000100
dsprm rd 88 0 00000200
dsprm rd 8c 0 00000040
dscmd wrc 90 00000009 0
dscmd dsin 00 0000001d -
dscmd irq 00 0 1
dscmd rd 90 0 0000001d
dscmd irq 00 0 0
dscmd dsin 00 0 -
timer wr 98 00000009 0
timer wr c8 00000003 0
timer wr f4 00000001 0
timer wr c4 00000001 0
timer irq 01 0 1
timer rdge c4 0 3
timer wr c4 00000001 0
timer irq 01 0 0
timer rdlt c4 0 3
unmap rd 40 0 0

// File: tests/tb_mcu_periph.sv
/*
 * MCU peripheral testbench
 * replays the transaction table from the data file under credit,
 * checks responses in order, dataslot ports, pulses and irqs
 */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module tb_mcu_periph;
	import mcu_pkg::*;

	logic		clk_sys, reset_n;
	logic		cmd_valid;
	bus_op_e	cmd_op;
	mcu_off_t	cmd_off;
	mcu_word_t	cmd_wdata;
	logic		ds_ack, ds_done;
	logic [2:0]	ds_err;
	logic		cmd_credit, rsp_valid, ds_read, ds_write, timer_irq, ext_irq;
	mcu_word_t	rsp_rdata, ds_bridge_addr, ds_length, ds_slot_offset;
	logic [15:0]	ds_id;

	string		t_name[$], t_op[$], t_exp[$];	// transaction table
	mcu_word_t	t_off[$], t_wdata[$];
	string		q_name[$];	// responses still owed, request order
	int		q_mode[$];	// 0 none, 1 equal, 2 at least, 3 below
	mcu_word_t	q_val[$];

	int	credits = `MCU_CMD_CREDITS;
	int	cycles = 0;
	int	limit = 2000;
	int	seed = 39258;
	int	rd_pulses = 0;
	int	wr_pulses = 0;

	tb_clock_gen clock_gen_i (.clk_sys, .reset_n);

	mcu_periph_top mcu_periph_top_i (.*);

	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic next_slot();
		@(posedge clk_sys);
		#1;	// drive point
	endtask

	// dataslot port behind a register offset
	function automatic mcu_word_t port_value(input mcu_word_t off);
		case (off[7:0])
			`MCU_REG_DS_ID:     return {16'h0, ds_id};
			`MCU_REG_DS_ADDR:   return ds_bridge_addr;
			`MCU_REG_DS_LEN:    return ds_length;
			`MCU_REG_DS_OFFSET: return ds_slot_offset;
			default:            return '0;
		endcase
	endfunction

	function automatic logic irq_level(input mcu_word_t sel);
		return sel[0] ? timer_irq : ext_irq;
	endfunction

	task automatic load_tests();
		int		fd;
		int		n;
		string		line, name, op, exptok;
		mcu_word_t	off, wdata;
		fd = $fopen("tests/mcu_periph_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test data file");
			stop_on_failure();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() == 0 || line.substr(0, 0) == "#")
				continue;	// column notes
			n = $sscanf(line, "%s %s %h %h %s", name, op, off, wdata, exptok);
			if (n != 5)
				continue;	// blank line
			t_name.push_back(name);
			t_op.push_back(op);
			t_off.push_back(off);
			t_wdata.push_back(wdata);
			t_exp.push_back(exptok);
		end
		$fclose(fd);
	endtask

	// one request under credit, expected response queued first
	task automatic send(input bus_op_e op, input mcu_word_t off, input mcu_word_t wdata,
			input string name, input string exptok, input int mode);
		mcu_word_t v;
		v = '0;
		while (credits == 0)
			next_slot();
		if (exptok == "-")
			mode = 0;
		else
			void'($sscanf(exptok, "%h", v));
		q_name.push_back(name);
		q_mode.push_back(mode);
		q_val.push_back(v);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_off   = off[7:0];
		cmd_wdata = wdata;
		credits--;
		next_slot();
		cmd_valid = 1'b0;
	endtask

	task automatic drain();
		while (credits != `MCU_CMD_CREDITS)
			next_slot();	// all credits back means all responses in
	endtask

	task automatic check_response();
		string		name, rel;
		int		mode;
		mcu_word_t	exp_v;
		logic		ok;
		assert (q_name.size() != 0) else begin
			$display("a response arrived with no request outstanding");
			stop_on_failure();
		end
		name  = q_name.pop_front();
		mode  = q_mode.pop_front();
		exp_v = q_val.pop_front();
		case (mode)
			1:       ok = (rsp_rdata == exp_v);
			2:       ok = (rsp_rdata >= exp_v);
			3:       ok = (rsp_rdata < exp_v);
			default: ok = 1'b1;
		endcase
		rel = (mode == 2) ? ">= " : (mode == 3) ? "< " : "";
		assert (ok) else begin
			$display("Error: %s expected %s%h actual %h", name, rel, exp_v, rsp_rdata);
			stop_on_failure();
		end
	endtask

	// sampled on the edge, outputs are flop driven
	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, run still busy after %0d cycles", limit);
			stop_on_failure();
		end
		assert (mcu_periph_top_i.mcu_periph_checker_i.fail_cnt == 0) else begin
			$display("a protocol assertion in the checker failed");
			stop_on_failure();
		end
		if (reset_n) begin
			if (ds_read)
				rd_pulses++;
			if (ds_write)
				wr_pulses++;
			if (cmd_credit)
				credits++;
			assert (credits <= `MCU_CMD_CREDITS) else begin
				$display("more credits returned than were spent");
				stop_on_failure();
			end
			if (rsp_valid)
				check_response();
		end
	end

	initial begin
		int		rd0, wr0, gap;
		mcu_word_t	got;
		cmd_valid = 1'b0;
		cmd_op    = OP_READ;
		cmd_off   = '0;
		cmd_wdata = '0;
		ds_ack    = 1'b0;
		ds_done   = 1'b0;
		ds_err    = '0;
		load_tests();
		limit = t_name.size() * 20 + 2000;
		@(posedge reset_n);
		next_slot();
		foreach (t_name[i]) begin
			case (t_op[i])
				"wr":   send(OP_WRITE, t_off[i], t_wdata[i], t_name[i], t_exp[i], 1);
				"rd":   send(OP_READ, t_off[i], t_wdata[i], t_name[i], t_exp[i], 1);
				"rdge": send(OP_READ, t_off[i], t_wdata[i], t_name[i], t_exp[i], 2);
				"rdlt": send(OP_READ, t_off[i], t_wdata[i], t_name[i], t_exp[i], 3);
				"wrp": begin
					send(OP_WRITE, t_off[i], t_wdata[i], t_name[i], t_exp[i], 1);
					drain();
					got = port_value(t_off[i]);
					assert (got == t_wdata[i]) else begin
						$display("Error: %s expected %h actual %h", t_name[i], t_wdata[i], got);
						stop_on_failure();
					end
				end
				"wrc": begin
					rd0 = rd_pulses;
					wr0 = wr_pulses;
					send(OP_WRITE, t_off[i], t_wdata[i], t_name[i], t_exp[i], 1);
					drain();
					assert (rd_pulses - rd0 == t_wdata[i][0] && wr_pulses - wr0 == t_wdata[i][1])
					else begin
						$display("Error: %s expected pulses rd %0d wr %0d actual rd %0d wr %0d",
							t_name[i], t_wdata[i][0], t_wdata[i][1],
							rd_pulses - rd0, wr_pulses - wr0);
						stop_on_failure();
					end
				end
				"dsin": begin
					drain();
					{ds_ack, ds_done, ds_err} = t_wdata[i][4:0];	// host status
				end
				"irq": begin
					drain();
					got = '0;
					void'($sscanf(t_exp[i], "%h", got));
					while (irq_level(t_off[i]) != got[0])
						next_slot();	// stuck level ends in the timeout
				end
				default: begin
					$display("unknown operation %s in the test data", t_op[i]);
					stop_on_failure();
				end
			endcase
			gap = $unsigned($random(seed)) % 3;	// 0 spends both credits back to back
			repeat (gap) next_slot();
		end
		drain();
		assert (credits == `MCU_CMD_CREDITS && q_name.size() == 0) else begin
			$display("credits or responses missing at the end of the run");
			stop_on_failure();
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: tests/mcu_periph_checker.sv
/*
 * Bus protocol checker
 * bound into the peripheral top, watches response/credit pairing,
 * dataslot pulse exclusion, response count and the timer irq
 */
`timescale 1ns/1ps

module mcu_periph_checker (
	input  logic			clk_sys,
	input  logic			reset_n,
	input  logic			cmd_valid,
	input  logic			rsp_valid,
	input  logic			cmd_credit,
	input  logic			ds_read,
	input  logic			ds_write,
	input  logic			timer_irq,
	input  mcu_pkg::mcu_word_t	timer_cmp
);
	int	cmd_cnt;	// requests pushed
	int	rsp_cnt;	// responses seen
	int	fail_cnt = 0;	// polled by the testbench

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			cmd_cnt <= 0;
			rsp_cnt <= 0;
		end else begin
			cmd_cnt <= cmd_cnt + int'(cmd_valid);
			rsp_cnt <= rsp_cnt + int'(rsp_valid);
		end
	end

	a_rsp_credit: assert property (@(posedge clk_sys) disable iff (!reset_n)
		rsp_valid == cmd_credit)
		else begin
			fail_cnt++;
			$error("response and credit out of step");
		end

	a_ds_excl: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(ds_read && ds_write))
		else begin
			fail_cnt++;
			$error("ds_read and ds_write high together");
		end

	a_rsp_count: assert property (@(posedge clk_sys) disable iff (!reset_n)
		rsp_cnt + int'(rsp_valid) <= cmd_cnt)
		else begin
			fail_cnt++;
			$error("more responses than requests");
		end

	a_irq_cmp: assert property (@(posedge clk_sys) disable iff (!reset_n)
		timer_irq |-> timer_cmp != '0)
		else begin
			fail_cnt++;
			$error("timer irq with a zero compare value");
		end

endmodule

bind mcu_periph_top mcu_periph_checker mcu_periph_checker_i (.*);

// File: tests/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 10 ns clk_sys, reset_n low for the first three cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic	clk_sys,
	output logic	reset_n
);
	localparam time half_period = 5ns;

	initial begin
		clk_sys = 1'b0;
		forever #(half_period) clk_sys = ~clk_sys;
	end

	initial begin
		reset_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1 reset_n = 1'b1;	// released in the drive slot like the other inputs
	end

endmodule

// File: verilog/mcu_periph_top.sv
/*
 * MCU peripheral block
 * credit based register bus into mailbox, dataslot command
 * group and millisecond timer, all on clk_sys
 */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module mcu_periph_top (
	input  logic			clk_sys,
	input  logic			reset_n,
	input  logic			cmd_valid,	// one cycle per spent credit
	input  mcu_pkg::bus_op_e	cmd_op,
	input  mcu_pkg::mcu_off_t	cmd_off,
	input  mcu_pkg::mcu_word_t	cmd_wdata,
	input  logic			ds_ack,
	input  logic			ds_done,
	input  logic [2:0]		ds_err,
	output logic			cmd_credit,
	output logic			rsp_valid,
	output mcu_pkg::mcu_word_t	rsp_rdata,
	output logic			ds_read,
	output logic			ds_write,
	output logic [15:0]		ds_id,
	output mcu_pkg::mcu_word_t	ds_bridge_addr,
	output mcu_pkg::mcu_word_t	ds_length,
	output mcu_pkg::mcu_word_t	ds_slot_offset,
	output logic			timer_irq,
	output logic			ext_irq
);
	import mcu_pkg::*;

	// queue to sequencer
	logic		fifo_empty;
	logic		fifo_pop;
	bus_op_e	head_op;
	mcu_off_t	head_off;
	mcu_word_t	head_wdata;

	// sequencer to bank
	logic		reg_wr, reg_rd;
	mcu_off_t	reg_off;
	mcu_word_t	reg_wdata, reg_rdata;

	// bank to timer and back
	mcu_word_t	clk_per_ms, timer_cmp, ms_count;
	logic		timer_clear, cmp_hit;

	// no ready, the master never pushes without a credit
	mcu_cmd_fifo #(.depth(`MCU_CMD_DEPTH)) mcu_cmd_fifo_i (
		.clk_sys, .reset_n,
		.push(cmd_valid), .push_op(cmd_op), .push_off(cmd_off), .push_wdata(cmd_wdata),
		.pop(fifo_pop), .empty(fifo_empty),
		.head_op, .head_off, .head_wdata
	);

	mcu_bus_fsm mcu_bus_fsm_i (
		.clk_sys, .reset_n,
		.fifo_empty, .head_op, .head_off, .head_wdata, .reg_rdata,
		.fifo_pop, .reg_wr, .reg_rd, .reg_off, .reg_wdata,
		.rsp_valid, .rsp_rdata, .cmd_credit, .ds_read, .ds_write
	);

	mcu_reg_bank mcu_reg_bank_i (
		.clk_sys, .reset_n,
		.reg_wr, .reg_rd, .reg_off, .reg_wdata,
		.ds_ack, .ds_done, .ds_err, .ms_count, .cmp_hit,
		.reg_rdata, .ds_id, .ds_bridge_addr, .ds_length, .ds_slot_offset,
		.clk_per_ms, .timer_cmp, .timer_clear, .timer_irq, .ext_irq
	);

	mcu_ms_timer mcu_ms_timer_i (
		.clk_sys, .reset_n,
		.clear(timer_clear), .clk_per_ms, .cmp(timer_cmp),
		.ms_count, .cmp_hit
	);

endmodule

// File: mcu_regs/mcu_reg_bank.sv
/*
 * Peripheral register bank
 * mailbox, dataslot parameters, timer settings and irq flags,
 * read back through a registered mux, unmapped offsets give zero
 */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module mcu_reg_bank (
	input  logic			clk_sys,
	input  logic			reset_n,
	input  logic			reg_wr,
	input  logic			reg_rd,
	input  mcu_pkg::mcu_off_t	reg_off,
	input  mcu_pkg::mcu_word_t	reg_wdata,
	input  logic			ds_ack,		// host busy with the command
	input  logic			ds_done,	// host finished, level
	input  logic [2:0]		ds_err,
	input  mcu_pkg::mcu_word_t	ms_count,
	input  logic			cmp_hit,
	output mcu_pkg::mcu_word_t	reg_rdata,
	output logic [15:0]		ds_id,
	output mcu_pkg::mcu_word_t	ds_bridge_addr,
	output mcu_pkg::mcu_word_t	ds_length,
	output mcu_pkg::mcu_word_t	ds_slot_offset,
	output mcu_pkg::mcu_word_t	clk_per_ms,
	output mcu_pkg::mcu_word_t	timer_cmp,
	output logic			timer_clear,
	output logic			timer_irq,
	output logic			ext_irq
);
	import mcu_pkg::*;

	mcu_word_t	mailbox [8];
	logic		irq_en;		// dataslot done irq enable
	logic		irq_mask;	// timer irq mask
	logic		ds_done_q;
	logic		stat_rd;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < 8; i++)
				mailbox[i] <= '0;
			ds_id          <= '0;
			ds_bridge_addr <= '0;
			ds_length      <= '0;
			ds_slot_offset <= '0;
			irq_en         <= 1'b0;
			clk_per_ms     <= '0;
			timer_cmp      <= '0;
			irq_mask       <= 1'b0;
			timer_clear    <= 1'b0;
		end else begin
			timer_clear <= 1'b0;	// pulse
			if (reg_wr) begin
				case (reg_off)
					`MCU_REG_MAILBOX_0, `MCU_REG_MAILBOX_1, `MCU_REG_MAILBOX_2,
					`MCU_REG_MAILBOX_3, `MCU_REG_MAILBOX_4, `MCU_REG_MAILBOX_5,
					`MCU_REG_MAILBOX_6, `MCU_REG_MAILBOX_7:
						mailbox[reg_off[4:2]] <= reg_wdata;
					`MCU_REG_DS_ID:       ds_id          <= reg_wdata[15:0];
					`MCU_REG_DS_ADDR:     ds_bridge_addr <= reg_wdata;
					`MCU_REG_DS_LEN:      ds_length      <= reg_wdata;
					`MCU_REG_DS_OFFSET:   ds_slot_offset <= reg_wdata;
					`MCU_REG_DS_CTRL:     irq_en         <= reg_wdata[3];	// b1:0 pulsed by the sequencer
					`MCU_REG_CLK_PER_MS:  clk_per_ms     <= reg_wdata;
					`MCU_REG_TIMER_COUNT: timer_clear    <= reg_wdata[0];
					`MCU_REG_TIMER_CMP:   timer_cmp      <= reg_wdata;
					`MCU_REG_IRQ_MASK:    irq_mask       <= reg_wdata[0];
					default: ;
				endcase
			end
		end
	end

	// read mux, registered on the EXEC strobe
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			reg_rdata <= '0;
		end else if (reg_rd) begin
			case (reg_off)
				`MCU_REG_MAILBOX_0, `MCU_REG_MAILBOX_1, `MCU_REG_MAILBOX_2,
				`MCU_REG_MAILBOX_3, `MCU_REG_MAILBOX_4, `MCU_REG_MAILBOX_5,
				`MCU_REG_MAILBOX_6, `MCU_REG_MAILBOX_7:
					reg_rdata <= mailbox[reg_off[4:2]];
				`MCU_REG_DS_ID:       reg_rdata <= {16'h0, ds_id};
				`MCU_REG_DS_ADDR:     reg_rdata <= ds_bridge_addr;
				`MCU_REG_DS_LEN:      reg_rdata <= ds_length;
				`MCU_REG_DS_OFFSET:   reg_rdata <= ds_slot_offset;
				`MCU_REG_DS_CTRL:     reg_rdata <= {27'h0, ds_ack, ds_done, ds_err};	// live status
				`MCU_REG_CLK_PER_MS:  reg_rdata <= clk_per_ms;
				`MCU_REG_TIMER_COUNT: reg_rdata <= ms_count;
				`MCU_REG_TIMER_CMP:   reg_rdata <= timer_cmp;
				`MCU_REG_IRQ_MASK:    reg_rdata <= {31'h0, irq_mask};
				default:              reg_rdata <= '0;	// unmapped
			endcase
		end
	end

	// done rising edge latches the irq, a status read drops it
	assign stat_rd = reg_rd && (reg_off == `MCU_REG_DS_CTRL);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			ds_done_q <= 1'b0;
			ext_irq   <= 1'b0;
		end else begin
			ds_done_q <= ds_done;
			if (stat_rd)
				ext_irq <= 1'b0;
			if (ds_done && !ds_done_q && irq_en)
				ext_irq <= 1'b1;	// a new edge wins over the clear
		end
	end

	assign timer_irq = cmp_hit && irq_mask;

endmodule

// File: mcu_regs/mcu_bus_fsm.sv
/*
 * Register bus sequencer
 * pops queued requests, strobes the register bank, fires the
 * dataslot pulses and returns response and credit together
 */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module mcu_bus_fsm (
	input  logic			clk_sys,
	input  logic			reset_n,
	input  logic			fifo_empty,
	input  mcu_pkg::bus_op_e	head_op,
	input  mcu_pkg::mcu_off_t	head_off,
	input  mcu_pkg::mcu_word_t	head_wdata,
	input  mcu_pkg::mcu_word_t	reg_rdata,	// registered by the bank
	output logic			fifo_pop,
	output logic			reg_wr,
	output logic			reg_rd,
	output mcu_pkg::mcu_off_t	reg_off,
	output mcu_pkg::mcu_word_t	reg_wdata,
	output logic			rsp_valid,
	output mcu_pkg::mcu_word_t	rsp_rdata,
	output logic			cmd_credit,
	output logic			ds_read,
	output logic			ds_write
);
	import mcu_pkg::*;

	bus_state_e	state;
	bus_op_e	cur_op;		// request being served
	mcu_off_t	cur_off;
	mcu_word_t	cur_wdata;
	logic		exec_wr;
	logic		ctrl_wr;

	// take the head only when idle
	assign fifo_pop = (state == IDLE) && !fifo_empty;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			state   <= IDLE;
			cur_op  <= OP_READ;
			cur_off <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (!fifo_empty) begin
						state   <= EXEC;
						cur_op  <= head_op;
						cur_off <= head_off;
					end
				end
				EXEC:    state <= RESP;	// bank access this cycle
				RESP:    state <= IDLE;	// rdata now settled
				default: state <= IDLE;
			endcase
		end
	end

	// write data travels with the request
	always_ff @(posedge clk_sys) begin
		if (fifo_pop)
			cur_wdata <= head_wdata;
	end

	// bank strobes, one cycle in EXEC
	assign exec_wr   = (state == EXEC) && (cur_op == OP_WRITE);
	assign reg_wr    = exec_wr;
	assign reg_rd    = (state == EXEC) && (cur_op == OP_READ);
	assign reg_off   = cur_off;
	assign reg_wdata = cur_wdata;

	// dataslot command, pulses straight from the control write
	assign ctrl_wr  = exec_wr && (cur_off == `MCU_REG_DS_CTRL);
	assign ds_read  = ctrl_wr && cur_wdata[0];
	assign ds_write = ctrl_wr && cur_wdata[1];

	// response and credit leave together, one cycle after RESP
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rsp_valid  <= 1'b0;
			cmd_credit <= 1'b0;
		end else begin
			rsp_valid  <= (state == RESP);
			cmd_credit <= (state == RESP);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == RESP)
			rsp_rdata <= (cur_op == OP_READ) ? reg_rdata : '0;	// writes answer zero
	end

endmodule

// File: verilog/mcu_ms_timer.sv
/*
 * Millisecond timer
 * cycle divider ticks the ms counter every clk_per_ms + 1 clocks,
 * sticky compare flag against a nonzero compare value
 */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module mcu_ms_timer (
	input  logic			clk_sys,
	input  logic			reset_n,
	input  logic			clear,		// sync, zeroes divider, count and flag
	input  mcu_pkg::mcu_word_t	clk_per_ms,
	input  mcu_pkg::mcu_word_t	cmp,
	output mcu_pkg::mcu_word_t	ms_count,
	output logic			cmp_hit
);
	import mcu_pkg::*;

	mcu_word_t	tick_cnt;	// clocks into the current ms
	logic		cmp_armed;

	// zero compare disables the flag
	assign cmp_armed = (cmp != {`MCU_DATA_W{1'b0}});

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_cnt <= '0;
			ms_count <= '0;
			cmp_hit  <= 1'b0;
		end else if (clear) begin
			tick_cnt <= '0;
			ms_count <= '0;
			cmp_hit  <= 1'b0;
		end else begin
			// >= so a lowered divisor cannot run past the terminal count
			if (tick_cnt >= clk_per_ms) begin
				tick_cnt <= '0;
				ms_count <= ms_count + 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end

			if (cmp_armed && ms_count >= cmp)
				cmp_hit <= 1'b1;	// held until clear
		end
	end

endmodule

// File: verilog/mcu_cmd_fifo.sv
/*
 * Command queue
 * small circular buffer for requests sent under credit, the
 * head entry is read straight out of registered storage
 */
`timescale 1ns/1ps

module mcu_cmd_fifo #(
	parameter int depth = 2
) (
	input  logic			clk_sys,
	input  logic			reset_n,
	input  logic			push,
	input  mcu_pkg::bus_op_e	push_op,
	input  mcu_pkg::mcu_off_t	push_off,
	input  mcu_pkg::mcu_word_t	push_wdata,
	input  logic			pop,
	output logic			empty,
	output mcu_pkg::bus_op_e	head_op,
	output mcu_pkg::mcu_off_t	head_off,
	output mcu_pkg::mcu_word_t	head_wdata
);
	import mcu_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	bus_op_e		op_mem [depth];
	mcu_off_t		off_mem [depth];
	mcu_word_t		wdata_mem [depth];
	logic [ptr_w-1:0]	wr_ptr, rd_ptr;
	logic [cnt_w-1:0]	count;	// occupancy

	// wrap at depth, depth need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (push) begin
			op_mem[wr_ptr]    <= push_op;
			off_mem[wr_ptr]   <= push_off;
			wdata_mem[wr_ptr] <= push_wdata;
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;	// both or neither, level unchanged
			endcase
		end
	end

	assign empty      = (count == '0);
	assign head_op    = op_mem[rd_ptr];
	assign head_off   = off_mem[rd_ptr];
	assign head_wdata = wdata_mem[rd_ptr];

endmodule

// File: common/mcu_pkg.sv
/*
 * MCU peripheral types
 * data and offset words for the register bus, the request
 * sequencer states and the bus opcodes
 */
`include "mcu_defs.svh"

package mcu_pkg;

	// one register bus word
	typedef logic [`MCU_DATA_W-1:0] mcu_word_t;

	// byte offset into the register map, word aligned
	typedef logic [`MCU_OFF_W-1:0] mcu_off_t;

	// request sequencer
	typedef enum logic [1:0] {
		IDLE,	// wait for a queued request
		EXEC,	// strobe the register bank
		RESP	// hand back data and credit
	} bus_state_e;

	// command carried on the bus
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} bus_op_e;

endpackage

// File: common/mcu_defs.svh
/*
 * MCU peripheral constants
 * bus widths, command queue depth, master credits and the
 * word offsets of every register in the peripheral map
 */
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

`define MCU_DATA_W		32	// register bus data width
`define MCU_OFF_W		8	// only addr[7:0] decoded
`define MCU_CMD_DEPTH		2	// command queue entries
`define MCU_CMD_CREDITS	2	// master credits after reset, matches queue depth

// mailbox, software scratch
`define MCU_REG_MAILBOX_0	8'h00
`define MCU_REG_MAILBOX_1	8'h04
`define MCU_REG_MAILBOX_2	8'h08
`define MCU_REG_MAILBOX_3	8'h0C
`define MCU_REG_MAILBOX_4	8'h10
`define MCU_REG_MAILBOX_5	8'h14
`define MCU_REG_MAILBOX_6	8'h18
`define MCU_REG_MAILBOX_7	8'h1C

// dataslot command group
`define MCU_REG_DS_ID		8'h80
`define MCU_REG_DS_ADDR		8'h84
`define MCU_REG_DS_LEN		8'h88
`define MCU_REG_DS_OFFSET	8'h8C
`define MCU_REG_DS_CTRL		8'h90	// wr: b0 rd, b1 wr, b3 irq en / rd: b4 ack, b3 done, b2:0 err

`define MCU_REG_CLK_PER_MS	8'h98
`define MCU_REG_TIMER_COUNT	8'hC4	// write b0 = 1 clears the timer
`define MCU_REG_TIMER_CMP	8'hC8
`define MCU_REG_IRQ_MASK	8'hF4	// b0 timer irq mask

`endif
